/* Makefile */
LOG = sim.log

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f files.f --top-module cpu_tb -o cpu_tb
	./obj_dir/cpu_tb | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

/* files.f */
+incdir+verif
rtl/cpu_pkg.sv
rtl/reg_file.sv
rtl/instr_decode.sv
rtl/alu_execute.sv
rtl/result_stage.sv
rtl/cpu.sv
verif/cpu_tb.sv

/* rtl/alu_execute.sv */
`timescale 1ns/1ps

module alu_execute import cpu_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  ex_ctrl_t  ex,
    input  wb_t       wb,
    output flags_t    flags_next,
    output res_ctrl_t res
);

    logic      fwd;
    word_t     a;
    word_t     b;
    word_t     sum;
    word_t     diff;
    logic      sum_ovf;
    logic      diff_ovf;
    word_t     sat;
    logic [31:0] rot;
    word_t     result;
    logic      sets_nv;
    logic      sets_z;
    flags_t    flags_q;
    res_ctrl_t res_next;

    // the instruction in result is one ahead, take its value when it matches
    assign fwd = wb.valid && (wb.rd != '0);
    assign a   = (fwd && wb.rd == ex.rs_idx) ? wb.data : ex.rs_val;
    assign b   = (fwd && wb.rd == ex.rt_idx) ? wb.data : ex.rt_val;

    assign sum      = a + b;
    assign diff     = a - b;
    assign sum_ovf  = (a[15] == b[15]) && (sum[15] != a[15]);
    assign diff_ovf = (a[15] != b[15]) && (diff[15] != a[15]);
    // on overflow the true result has the sign of a in both cases
    assign sat      = a[15] ? 16'h8000 : 16'h7fff;
    assign rot      = {a, a} >> ex.imm[3:0];

    always_comb begin
        case (ex.op)
            OP_ADD:        result = sum_ovf ? sat : sum;
            OP_SUB:        result = diff_ovf ? sat : diff;
            OP_XOR:        result = a ^ b;
            OP_SLL:        result = a << ex.imm[3:0];
            OP_SRA:        result = word_t'($signed(a) >>> ex.imm[3:0]);
            OP_ROR:        result = rot[15:0];
            // word aligned base plus byte offset
            OP_LW, OP_SW:  result = (a & 16'hfffe) + ex.imm;
            OP_LLB:        result = {a[15:8], ex.imm[7:0]};
            OP_LHB:        result = {ex.imm[7:0], a[7:0]};
            OP_PCS:        result = ex.imm;
            default:       result = '0;
        endcase
    end

    // arithmetic sets all three flags, logic and shifts only z
    assign sets_nv = ex.valid && (ex.op == OP_ADD || ex.op == OP_SUB);
    assign sets_z  = sets_nv || (ex.valid && ex.op inside {OP_XOR, OP_SLL, OP_SRA, OP_ROR});

    assign flags_next.z = sets_z ? (result == '0) : flags_q.z;
    assign flags_next.n = sets_nv ? result[15] : flags_q.n;
    assign flags_next.v = sets_nv ? ((ex.op == OP_ADD) ? sum_ovf : diff_ovf) : flags_q.v;

    always_ff @(posedge clk) begin
        if (reset) flags_q <= '0;
        else flags_q <= flags_next;
    end

    always_comb begin
        res_next.valid      = ex.valid;
        res_next.rd         = ex.rd;
        res_next.write_reg  = ex.write_reg;
        res_next.mem_read   = (ex.op == OP_LW);
        res_next.mem_write  = (ex.op == OP_SW);
        res_next.hlt        = (ex.op == OP_HLT);
        res_next.value      = result;
        // store data comes through the rt operand
        res_next.store_data = b;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            res.valid     <= 1'b0;
            res.write_reg <= 1'b0;
            res.mem_read  <= 1'b0;
            res.mem_write <= 1'b0;
            res.hlt       <= 1'b0;
        end else begin
            res <= res_next;
        end
    end

endmodule

/* rtl/cpu.sv */
`timescale 1ns/1ps

module cpu import cpu_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    output word_t  pc,
    input  instr_t instr,
    output logic   hlt,
    output wb_t    wb
);

    reg_idx_t  rs_idx;
    reg_idx_t  rt_idx;
    word_t     rs_val;
    word_t     rt_val;
    flags_t    flags_next;
    ex_ctrl_t  ex;
    res_ctrl_t res;

    // read in decode, written from result
    reg_file reg_file_i (
        .clk    (clk),
        .reset  (reset),
        .rs_idx (rs_idx),
        .rt_idx (rt_idx),
        .wb     (wb),
        .rs_val (rs_val),
        .rt_val (rt_val)
    );

    // fetch, decode and branch resolution
    instr_decode instr_decode_i (
        .clk        (clk),
        .reset      (reset),
        .instr      (instr),
        .pc         (pc),
        .flags_next (flags_next),
        .rs_idx     (rs_idx),
        .rt_idx     (rt_idx),
        .rs_val     (rs_val),
        .rt_val     (rt_val),
        .ex         (ex)
    );

    // flags loop back to decode for B in the same cycle
    alu_execute alu_execute_i (
        .clk        (clk),
        .reset      (reset),
        .ex         (ex),
        .wb         (wb),
        .flags_next (flags_next),
        .res        (res)
    );

    // memory access and write-back
    result_stage result_stage_i (
        .clk   (clk),
        .reset (reset),
        .res   (res),
        .wb    (wb),
        .hlt   (hlt)
    );

endmodule

/* rtl/cpu_pkg.sv */
package cpu_pkg;

    typedef logic [15:0] word_t;
    typedef logic [3:0]  reg_idx_t;
    typedef logic [15:0] instr_t;

    localparam int    DMEM_WORDS = 256;
    // addresses count bytes, one instruction is two of them
    localparam word_t PC_STEP    = 16'd2;
    localparam word_t RESET_PC   = 16'h0000;

    // 0011 and 0111 are spare codes and run as no-ops
    typedef enum logic [3:0] {
        OP_ADD = 4'b0000, OP_SUB = 4'b0001, OP_XOR = 4'b0010, OP_NOP3 = 4'b0011,
        OP_SLL = 4'b0100, OP_SRA = 4'b0101, OP_ROR = 4'b0110, OP_NOP7 = 4'b0111,
        OP_LW  = 4'b1000, OP_SW  = 4'b1001, OP_LLB = 4'b1010, OP_LHB  = 4'b1011,
        OP_B   = 4'b1100, OP_BR  = 4'b1101, OP_PCS = 4'b1110, OP_HLT  = 4'b1111
    } opcode_e;

    typedef enum logic [2:0] {
        COND_NE = 3'b000, COND_EQ = 3'b001, COND_GT = 3'b010, COND_LT = 3'b011,
        COND_GE = 3'b100, COND_LE = 3'b101, COND_OV = 3'b110, COND_AL = 3'b111
    } cond_e;

    typedef struct packed {
        logic z;
        logic n;
        logic v;
    } flags_t;

    // decode to execute
    typedef struct packed {
        logic     valid;
        opcode_e  op;
        reg_idx_t rd;
        reg_idx_t rs_idx;
        reg_idx_t rt_idx;
        word_t    rs_val;
        word_t    rt_val;
        word_t    imm;
        logic     write_reg;
    } ex_ctrl_t;

    // execute to result, value is the ALU result or the memory address
    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        logic     write_reg;
        logic     mem_read;
        logic     mem_write;
        logic     hlt;
        word_t    value;
        word_t    store_data;
    } res_ctrl_t;

    // valid here means a register is written this cycle
    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    data;
    } wb_t;

    // branch condition against a flag set
    function automatic logic cond_met(cond_e c, flags_t f);
        logic t;
        case (c)
            COND_NE: t = !f.z;
            COND_EQ: t = f.z;
            COND_GT: t = !f.z && !f.n;
            COND_LT: t = f.n;
            COND_GE: t = f.z || !f.n;
            COND_LE: t = f.n || f.z;
            COND_OV: t = f.v;
            default: t = 1'b1;
        endcase
        return t;
    endfunction

    // opcodes that put a result into rd
    function automatic logic writes_reg(opcode_e op);
        return op inside {OP_ADD, OP_SUB, OP_XOR, OP_SLL, OP_SRA, OP_ROR,
                          OP_LW, OP_LLB, OP_LHB, OP_PCS};
    endfunction

endpackage

/* rtl/instr_decode.sv */
`timescale 1ns/1ps

module instr_decode import cpu_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  instr_t   instr,
    output word_t    pc,
    input  flags_t   flags_next,
    output reg_idx_t rs_idx,
    output reg_idx_t rt_idx,
    input  word_t    rs_val,
    input  word_t    rt_val,
    output ex_ctrl_t ex
);

    opcode_e  op;
    cond_e    cond;
    reg_idx_t rd;
    word_t    pc_plus;
    word_t    pc_next;
    word_t    b_target;
    logic     taken;
    logic     halted;
    ex_ctrl_t ex_next;

    assign op   = opcode_e'(instr[15:12]);
    assign cond = cond_e'(instr[11:9]);
    assign rd   = instr[11:8];

    // byte loads modify rd in place, stores read their data from 11:8
    assign rs_idx = (op == OP_LLB || op == OP_LHB) ? rd : instr[7:4];
    assign rt_idx = (op == OP_SW) ? rd : instr[3:0];

    assign pc_plus  = pc + PC_STEP;
    // 9-bit word offset, sign extended and turned into bytes
    assign b_target = pc_plus + {{6{instr[8]}}, instr[8:0], 1'b0};
    // flags_next already holds the effect of the instruction in execute
    assign taken    = (op == OP_B || op == OP_BR) && cond_met(cond, flags_next);

    always_comb begin
        if (halted || op == OP_HLT) begin
            pc_next = pc;
        end else if (taken) begin
            pc_next = (op == OP_BR) ? rs_val : b_target;
        end else begin
            pc_next = pc_plus;
        end
    end

    always_comb begin
        ex_next.valid     = !halted;
        ex_next.op        = op;
        ex_next.rd        = rd;
        ex_next.rs_idx    = rs_idx;
        ex_next.rt_idx    = rt_idx;
        ex_next.rs_val    = rs_val;
        ex_next.rt_val    = rt_val;
        ex_next.write_reg = writes_reg(op);
        case (op)
            // shift amount
            OP_SLL, OP_SRA, OP_ROR: ex_next.imm = {12'h000, instr[3:0]};
            // signed word offset in bytes
            OP_LW, OP_SW:           ex_next.imm = {{11{instr[3]}}, instr[3:0], 1'b0};
            OP_LLB, OP_LHB:         ex_next.imm = {8'h00, instr[7:0]};
            // return address for PCS
            OP_PCS:                 ex_next.imm = pc_plus;
            default:                ex_next.imm = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc     <= RESET_PC;
            halted <= 1'b0;
        end else begin
            pc <= pc_next;
            if (op == OP_HLT) halted <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ex.valid     <= 1'b0;
            ex.write_reg <= 1'b0;
        end else begin
            ex <= ex_next;
        end
    end

endmodule

/* rtl/reg_file.sv */
`timescale 1ns/1ps

module reg_file import cpu_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t rs_idx,
    input  reg_idx_t rt_idx,
    input  wb_t      wb,
    output word_t    rs_val,
    output word_t    rt_val
);

    word_t regs [16];

    // r0 is never written, so it stays at its reset zero
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // write-through, a read of the register being written sees the new data
    function automatic word_t read_port(reg_idx_t idx);
        if (idx == '0) return '0;
        if (wb.valid && wb.rd == idx) return wb.data;
        return regs[idx];
    endfunction

    assign rs_val = read_port(rs_idx);
    assign rt_val = read_port(rt_idx);

endmodule

/* rtl/result_stage.sv */
`timescale 1ns/1ps

module result_stage import cpu_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  res_ctrl_t res,
    output wb_t       wb,
    output logic      hlt
);

    word_t dmem [DMEM_WORDS];
    logic [$clog2(DMEM_WORDS)-1:0] widx;
    logic  hlt_q;

    // byte address to word index
    assign widx = res.value[$clog2(DMEM_WORDS):1];

    always_ff @(posedge clk) begin
        if (res.valid && res.mem_write) dmem[widx] <= res.store_data;
    end

    // asynchronous read, a load right after a store sees the stored word
    assign wb.valid = res.valid && res.write_reg;
    assign wb.rd    = res.rd;
    assign wb.data  = res.mem_read ? dmem[widx] : res.value;

    // halt is sticky once HLT arrives here
    always_ff @(posedge clk) begin
        if (reset) hlt_q <= 1'b0;
        else if (res.valid && res.hlt) hlt_q <= 1'b1;
    end

    assign hlt = hlt_q || (res.valid && res.hlt);

endmodule

/* verif/cpu_model.svh */
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

// reference model and program builder for the cpu testbench
// the including scope imports cpu_pkg

int unsigned lcg_state = 32'h26fdea1d;

// operand source, upper half of a 32-bit LCG
function automatic word_t lcg_word();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];
endfunction

// register format, also shifts (rt is the amount) and LW/SW (rd is data, rt is offset)
function automatic instr_t enc_r(opcode_e op, reg_idx_t rd, reg_idx_t rs, logic [3:0] rt);
    return {op, rd, rs, rt};
endfunction

// LLB, LHB, PCS and HLT
function automatic instr_t enc_i8(opcode_e op, reg_idx_t rd, logic [7:0] u8);
    return {op, rd, u8};
endfunction

function automatic instr_t enc_b(cond_e c, logic [8:0] off);
    return {OP_B, c, off};
endfunction

function automatic instr_t enc_br(cond_e c, reg_idx_t rs);
    return {OP_BR, c, 1'b0, rs, 4'h0};
endfunction

// condition table of the ISA, one bit per code
function automatic logic branch_taken(logic [2:0] c, flags_t f);
    logic [7:0] met;
    met = {1'b1, f.v, f.n | f.z, f.z | !f.n, f.n, !f.z & !f.n, f.z, !f.z};
    return met[c];
endfunction

// full word into rd with LLB then LHB
function automatic void put_word(ref instr_t prog[$], input reg_idx_t rd, input word_t w);
    prog.push_back(enc_i8(OP_LLB, rd, w[7:0]));
    prog.push_back(enc_i8(OP_LHB, rd, w[15:8]));
endfunction

function automatic void build_program(ref instr_t prog[$]);
    word_t    sh;
    reg_idx_t rx;
    reg_idx_t ry;
    int       base;
    prog.delete();
    for (int r = 1; r <= 6; r++) put_word(prog, reg_idx_t'(r), lcg_word());
    // saturation corners, 7000 and 9000
    put_word(prog, 4'd7, 16'h7000);
    put_word(prog, 4'd8, 16'h9000);
    prog.push_back(enc_r(OP_ADD, 4'd9, 4'd7, 4'd7));
    prog.push_back(enc_r(OP_ADD, 4'd10, 4'd8, 4'd8));
    prog.push_back(enc_r(OP_SUB, 4'd11, 4'd8, 4'd7));
    prog.push_back(enc_r(OP_SUB, 4'd12, 4'd7, 4'd8));
    // dependent chain through forwarding
    prog.push_back(enc_r(OP_ADD, 4'd9, 4'd1, 4'd2));
    prog.push_back(enc_r(OP_SUB, 4'd9, 4'd9, 4'd3));
    prog.push_back(enc_r(OP_XOR, 4'd10, 4'd9, 4'd4));
    for (int k = 0; k < 3; k++) begin
        sh = lcg_word();
        prog.push_back(enc_r(OP_SLL, 4'd10, 4'd10, sh[3:0]));
        prog.push_back(enc_r(OP_SRA, 4'd11, 4'd10, sh[7:4]));
        prog.push_back(enc_r(OP_ROR, 4'd12, 4'd11, sh[11:8]));
        prog.push_back(enc_r(OP_ADD, 4'd10, 4'd12, 4'd5));
    end
    // stores and loads around 0x0040, offsets -1, +3 and -8 words
    put_word(prog, 4'd13, 16'h0040);
    prog.push_back(enc_r(OP_SW, 4'd1, 4'd13, 4'hf));
    prog.push_back(enc_r(OP_SW, 4'd2, 4'd13, 4'h3));
    prog.push_back(enc_r(OP_LW, 4'd14, 4'd13, 4'hf));
    prog.push_back(enc_r(OP_ADD, 4'd15, 4'd14, 4'd14));
    prog.push_back(enc_r(OP_SW, 4'd3, 4'd13, 4'h8));
    prog.push_back(enc_r(OP_LW, 4'd14, 4'd13, 4'h8));
    prog.push_back(enc_r(OP_LW, 4'd15, 4'd13, 4'h3));
    prog.push_back(enc_r(OP_XOR, 4'd15, 4'd15, 4'd14));
    // every condition, right after the flag setter and with a non-flag op between
    for (int c = 0; c < 8; c++) begin
        for (int k = 0; k < 2; k++) begin
            sh = lcg_word();
            rx = {2'b00, sh[1:0]} + 4'd1;
            ry = sh[5] ? rx : ({2'b01, sh[3:2]} + 4'd1);
            prog.push_back(enc_r(sh[4] ? OP_XOR : OP_SUB, 4'd9, rx, ry));
            if (k == 1) prog.push_back(enc_i8(OP_LLB, 4'd11, sh[15:8]));
            prog.push_back(enc_b(cond_e'(c), 9'd1));
            prog.push_back(enc_i8(OP_LLB, 4'd12, 8'hee));
        end
    end
    // PCS, then BR over one instruction to a register set two earlier
    base = prog.size();
    put_word(prog, 4'd14, word_t'((base + 5) * 2));
    prog.push_back(enc_i8(OP_PCS, 4'd13, 8'h00));
    prog.push_back(enc_br(COND_AL, 4'd14));
    prog.push_back(enc_i8(OP_LLB, 4'd12, 8'h77));
    prog.push_back(enc_r(OP_ADD, 4'd12, 4'd13, 4'd14));
    prog.push_back(enc_i8(OP_HLT, 4'd0, 8'h00));
endfunction

// in-order run of the program, one expected wb entry per register write
function automatic void run_model(input instr_t prog[$], ref wb_t exp[$],
                                  output word_t halt_pc);
    word_t   rf [16];
    word_t   dm [int];
    flags_t  fl;
    word_t   pc;
    word_t   a;
    word_t   b;
    word_t   r;
    word_t   addr;
    instr_t  ins;
    opcode_e op;
    logic    ovf;
    wb_t     e;
    exp.delete();
    fl = '0;
    pc = RESET_PC;
    halt_pc = '0;
    foreach (rf[i]) rf[i] = '0;
    for (int step = 0; step < 4 * prog.size(); step++) begin
        ins  = prog[pc >> 1];
        op   = opcode_e'(ins[15:12]);
        a    = rf[(op == OP_LLB || op == OP_LHB) ? ins[11:8] : ins[7:4]];
        b    = rf[(op == OP_SW) ? ins[11:8] : ins[3:0]];
        addr = (a & 16'hfffe) + {{11{ins[3]}}, ins[3:0], 1'b0};
        r    = '0;
        pc   = pc + PC_STEP;
        case (op)
            OP_ADD, OP_SUB: begin
                r   = (op == OP_ADD) ? a + b : a - b;
                ovf = (op == OP_ADD) ? (a[15] == b[15]) : (a[15] != b[15]);
                ovf = ovf && (r[15] != a[15]);
                if (ovf) r = a[15] ? 16'h8000 : 16'h7fff;
                fl.n = r[15];
                fl.v = ovf;
            end
            OP_XOR: r = a ^ b;
            OP_SLL: r = a << ins[3:0];
            OP_SRA: r = $signed(a) >>> ins[3:0];
            OP_ROR: r = (a >> ins[3:0]) | (a << (16 - ins[3:0]));
            OP_LW:  r = dm.exists(int'(addr[8:1])) ? dm[int'(addr[8:1])] : '0;
            OP_SW:  dm[int'(addr[8:1])] = b;
            OP_LLB: r = {a[15:8], ins[7:0]};
            OP_LHB: r = {ins[7:0], a[7:0]};
            OP_B:   if (branch_taken(ins[11:9], fl)) pc = pc + {{6{ins[8]}}, ins[8:0], 1'b0};
            OP_BR:  if (branch_taken(ins[11:9], fl)) pc = rf[ins[7:4]];
            OP_PCS: r = pc;
            OP_HLT: begin
                halt_pc = pc - PC_STEP;
                return;
            end
            default: r = '0;
        endcase
        if (op inside {OP_ADD, OP_SUB, OP_XOR, OP_SLL, OP_SRA, OP_ROR}) fl.z = (r == '0);
        // stores, branches and the spare codes leave the registers alone
        if (!(op inside {OP_SW, OP_B, OP_BR, OP_NOP3, OP_NOP7})) begin
            e.valid = 1'b1;
            e.rd    = ins[11:8];
            e.data  = r;
            exp.push_back(e);
            if (ins[11:8] != 4'd0) rf[ins[11:8]] = r;
        end
    end
endfunction

`endif

/* verif/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb import cpu_pkg::*; ();

    `include "cpu_model.svh"

    logic   clk = 1'b0;
    logic   reset = 1'b1;
    word_t  pc;
    instr_t instr;
    logic   hlt;
    wb_t    wb;

    // program, expected write-backs and where the model stops
    instr_t prog [$];
    wb_t    exp_wb [$];
    word_t  halt_pc;
    int     prog_len = 0;
    int     exp_idx = 0;
    int     errors = 0;

    // instruction memory, word index from the byte pc
    instr_t imem [256];

    cpu cpu_i (
        .clk   (clk),
        .reset (reset),
        .pc    (pc),
        .instr (instr),
        .hlt   (hlt),
        .wb    (wb)
    );

    // fetch is combinational in the same cycle
    assign instr = imem[pc[8:1]];

    initial begin
        forever #20 clk = ~clk;
    end

    // next write-back against the head of the expected list
    task automatic check_wb();
        assert (exp_idx < exp_wb.size()) else begin
            errors++;
            $display("write-back to r%0d arrived after all expected write-backs", wb.rd);
        end
        if (exp_idx < exp_wb.size()) begin
            assert (wb.rd == exp_wb[exp_idx].rd) else begin
                errors++;
                $display("Fail wb.rd: got %h expected %h at write-back %0d",
                         wb.rd, exp_wb[exp_idx].rd, exp_idx);
            end
            assert (wb.data == exp_wb[exp_idx].data) else begin
                errors++;
                $display("Fail wb.data: got %h expected %h at write-back %0d",
                         wb.data, exp_wb[exp_idx].data, exp_idx);
            end
            exp_idx++;
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            if (wb.valid) check_wb();
            if (hlt) begin
                // pc parked on the HLT itself
                assert (pc == halt_pc) else begin
                    errors++;
                    $display("Fail pc: got %h expected %h while halted", pc, halt_pc);
                end
                assert (!wb.valid) else begin
                    errors++;
                    $display("register r%0d was written after the halt", wb.rd);
                end
            end
        end
    end

    initial begin
        build_program(prog);
        run_model(prog, exp_wb, halt_pc);
        // spare words hold no-ops tagged with their own index
        foreach (imem[i]) imem[i] = {4'b0011, 12'(i)};
        foreach (prog[i]) imem[i] = prog[i];
        prog_len = prog.size();
        repeat (2) @(posedge clk);
        #2 reset = 1'b0;
        wait (hlt === 1'b1);
        // a few more cycles to catch anything after the halt
        repeat (4) @(posedge clk);
        #2;
        assert (exp_idx == exp_wb.size()) else begin
            errors++;
            $display("only %0d of %0d expected write-backs were seen", exp_idx, exp_wb.size());
        end
        $display("errors: %0d, write-backs checked: %0d of %0d",
                 errors, exp_idx, exp_wb.size());
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // generous bound, every instruction gets four cycles
    initial begin
        wait (prog_len > 0);
        repeat (prog_len * 4 + 20) @(posedge clk);
        $display("timeout, hlt did not rise within %0d cycles", prog_len * 4 + 20);
        $display("errors: %0d, write-backs checked: %0d of %0d",
                 errors, exp_idx, exp_wb.size());
        $display("Testbench failed");
        $finish;
    end

endmodule
